//--- build.f
hdl/board_pkg.sv
hdl/mdio_pkg.sv
hdl/switch_debounce.sv
hdl/phy_init_sequencer.sv
hdl/mdio_master.sv
hdl/board_mgmt_top.sv
tests/mdio_frame_monitor.sv
tests/tb_board_mgmt_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_board_mgmt_top -o sim_board_mgmt \
    && ./obj_dir/sim_board_mgmt | tee sim.log \
    && grep -q "^ALL CHECKS PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tests/tb_board_mgmt_top.sv
// Testbench for the board management top covering PHY setup frames, LED source and debounce
`default_nettype none
`timescale 1ns/1ps

module tb_board_mgmt_top;

    localparam int DB_RATE      = 16;
    localparam int INIT_DELAY   = 64;
    localparam int FRAME_COUNT  = 12;
    localparam int FRAME_CYCLES = 64 * 8;
    localparam int IDLE_CYCLES  = 2000;
    // Worst-case debounce response plus register stages
    localparam int DB_SETTLE    = (4 + 1) * DB_RATE + 2;
    // All tests back to back and doubled for margin
    localparam int TIMEOUT_CYCLES =
        2 * (INIT_DELAY + FRAME_COUNT * (FRAME_CYCLES + 8) + IDLE_CYCLES + 8 * DB_SETTLE);

    logic        clk_125mhz_int;
    logic        rst_125mhz_int;
    logic [4:0]  btn;
    logic [3:0]  sw;
    logic [7:0]  lock_word;
    logic [7:0]  core_led;
    logic        mdio_in;
    logic [7:0]  led;
    logic [4:0]  btn_db;
    logic [3:0]  sw_db;
    logic        mdc;
    logic        mdio_out;
    logic        mdio_oe;
    logic        init_done;
    logic [31:0] mon_preamble;
    logic [1:0]  mon_start;
    logic [1:0]  mon_op;
    logic [1:0]  mon_ta;
    logic [4:0]  mon_phy;
    logic [4:0]  mon_reg;
    logic [15:0] mon_data;
    logic [31:0] mon_count;
    logic [4:0]  exp_reg  [FRAME_COUNT];
    logic [15:0] exp_data [FRAME_COUNT];
    integer      seed;
    int          checks      = 0;
    int          errors      = 0;
    int          test_errors = 0;
    int          cycle_count = 0;
    int          busy_cycles;
    string       test_name;

    board_mgmt_top #(
        .DEBOUNCE_RATE(DB_RATE),
        .INIT_DELAY   (INIT_DELAY)
    ) board_mgmt_top_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .btn_i         (btn),
        .sw_i          (sw),
        .btn_o         (btn_db),
        .sw_o          (sw_db),
        .lock_i        (lock_word),
        .core_led_i    (core_led),
        .led_o         (led),
        .phy_mdio_i    (mdio_in),
        .phy_mdc_o     (mdc),
        .phy_mdio_o    (mdio_out),
        .phy_mdio_oe_o (mdio_oe),
        .init_done_o   (init_done)
    );

    mdio_frame_monitor frame_mon_i (
        .mdc_i        (mdc),
        .mdio_i       (mdio_out),
        .oe_i         (mdio_oe),
        .preamble_o   (mon_preamble),
        .start_o      (mon_start),
        .op_o         (mon_op),
        .phy_addr_o   (mon_phy),
        .reg_addr_o   (mon_reg),
        .ta_o         (mon_ta),
        .data_o       (mon_data),
        .frame_count_o(mon_count)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_equal(
        input string       label,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks++;
        assert (actual === expected) else begin
            $display("ERR %s/%s expected %0h actual %0h", test_name, label, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        $display("Test %s done with %0d errors", test_name, errors - test_errors);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_125mhz_int);
    endtask

    // Four indirect accesses per extended write in the order REGCR, address, REGCR, value
    task automatic build_expected_table();
        logic [15:0] ext_addr [3];
        logic [15:0] ext_val  [3];
        ext_addr = '{16'h0031, 16'h00D3, 16'h016F};
        ext_val  = '{16'h0070, 16'h4000, 16'h0015};
        for (int w = 0; w < 3; w++) begin
            exp_reg[4*w]    = 5'h0D;
            exp_data[4*w]   = 16'h001F;
            exp_reg[4*w+1]  = 5'h0E;
            exp_data[4*w+1] = ext_addr[w];
            exp_reg[4*w+2]  = 5'h0D;
            exp_data[4*w+2] = 16'h401F;
            exp_reg[4*w+3]  = 5'h0E;
            exp_data[4*w+3] = ext_val[w];
        end
    endtask

    initial begin
        seed           = 32'h7c3f0ba1;
        rst_125mhz_int = 1'b1;
        btn            = '0;
        sw             = '0;
        lock_word      = '0;
        core_led       = 8'($random(seed));
        mdio_in        = 1'b0;
        build_expected_table();
        wait_cycles(3);
        rst_125mhz_int = 1'b0;

        // Still inside the power-up delay
        start_test("reset_state");
        for (int i = 0; i < INIT_DELAY / 2; i++) begin
            @(negedge clk_125mhz_int);
            check_equal("mdc", 32'd0, 32'(mdc));
            check_equal("mdio_oe", 32'd0, 32'(mdio_oe));
            check_equal("init_done", 32'd0, 32'(init_done));
            check_equal("led_core", 32'(core_led), 32'(led));
        end
        finish_test();

        start_test("phy_frames");
        for (int n = 0; n < FRAME_COUNT; n++) begin
            while (mon_count == 32'(n)) begin
                @(negedge clk_125mhz_int);
            end
            check_equal("preamble", 32'hFFFF_FFFF, mon_preamble);
            check_equal("start", 32'h1, 32'(mon_start));
            check_equal("opcode", 32'h1, 32'(mon_op));
            check_equal("phy_addr", 32'h3, 32'(mon_phy));
            check_equal("turnaround", 32'h2, 32'(mon_ta));
            check_equal("reg_addr", 32'(exp_reg[n]), 32'(mon_reg));
            check_equal("data", 32'(exp_data[n]), 32'(mon_data));
        end
        check_equal("init_done", 32'd1, 32'(init_done));
        finish_test();

        start_test("no_extra_frames");
        while (mdio_oe) begin
            @(negedge clk_125mhz_int);
        end
        busy_cycles = 0;
        repeat (IDLE_CYCLES) begin
            @(negedge clk_125mhz_int);
            if (mdio_oe) begin
                busy_cycles++;
            end
        end
        check_equal("oe_cycles", 32'd0, 32'(busy_cycles));
        check_equal("frame_total", 32'(FRAME_COUNT), mon_count);
        check_equal("init_done_held", 32'd1, 32'(init_done));
        finish_test();

        start_test("led_select");
        sw[0] = 1'b1;
        wait_cycles(DB_SETTLE);
        check_equal("sw_high", 32'h1, 32'(sw_db));
        repeat (6) begin
            lock_word = 8'($random(seed));
            core_led  = 8'($random(seed));
            @(negedge clk_125mhz_int);
            check_equal("led_lock", 32'(lock_word), 32'(led));
        end
        sw[0] = 1'b0;
        wait_cycles(DB_SETTLE);
        check_equal("sw_low", 32'h0, 32'(sw_db));
        repeat (6) begin
            lock_word = 8'($random(seed));
            core_led  = 8'($random(seed));
            @(negedge clk_125mhz_int);
            check_equal("led_core", 32'(core_led), 32'(led));
        end
        finish_test();

        start_test("debounce");
        // Lock word differs from the core LEDs so a source change shows on led
        lock_word = ~core_led;
        // Pulse shorter than one sample period
        sw[0] = 1'b1;
        wait_cycles(DB_RATE - 1);
        sw[0] = 1'b0;
        busy_cycles = 0;
        repeat (DB_SETTLE) begin
            @(negedge clk_125mhz_int);
            if (led !== core_led) begin
                busy_cycles++;
            end
        end
        check_equal("glitch_cycles", 32'd0, 32'(busy_cycles));
        btn = 5'b10110;
        wait_cycles(DB_SETTLE);
        check_equal("btn_press", 32'h16, 32'(btn_db));
        btn = 5'b00000;
        wait_cycles(DB_SETTLE);
        check_equal("btn_release", 32'h0, 32'(btn_db));
        finish_test();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mdio_frame_monitor.sv
// MDIO frame monitor that samples the data line on rising MDC and decodes each write frame
`default_nettype none
`timescale 1ns/1ps

module mdio_frame_monitor (
    input  wire         mdc_i,
    input  wire         mdio_i,
    input  wire         oe_i,
    output logic [31:0] preamble_o,
    output logic [1:0]  start_o,
    output logic [1:0]  op_o,
    output logic [4:0]  phy_addr_o,
    output logic [4:0]  reg_addr_o,
    output logic [1:0]  ta_o,
    output logic [15:0] data_o,
    output logic [31:0] frame_count_o
);

    logic [63:0] bits;
    int          bit_cnt;

    initial begin
        bits          = '0;
        bit_cnt       = 0;
        preamble_o    = '0;
        start_o       = '0;
        op_o          = '0;
        phy_addr_o    = '0;
        reg_addr_o    = '0;
        ta_o          = '0;
        data_o        = '0;
        frame_count_o = '0;
    end

    // PHY side view of the bus, only driven bits count
    always @(posedge mdc_i) begin
        if (oe_i) begin
            bits = {bits[62:0], mdio_i};
            bit_cnt++;
            if (bit_cnt == 64) begin
                preamble_o = bits[63:32];
                start_o    = bits[31:30];
                op_o       = bits[29:28];
                phy_addr_o = bits[27:23];
                reg_addr_o = bits[22:18];
                ta_o       = bits[17:16];
                data_o     = bits[15:0];
                frame_count_o++;
                bit_cnt = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/board_mgmt_top.sv
// Board management top with input debounce, PHY MDIO setup and LED source selection
`default_nettype none
`timescale 1ns/1ps

module board_mgmt_top
    import board_pkg::*;
    import mdio_pkg::*;
#(
    parameter int DEBOUNCE_RATE = DEBOUNCE_RATE_DEFAULT,
    parameter int INIT_DELAY    = INIT_DELAY_DEFAULT
) (
    input  wire                 clk_125mhz_int,
    input  wire                 rst_125mhz_int,

    // Buttons u, l, d, r, c and switches
    input  wire [BTN_COUNT-1:0] btn_i,
    input  wire [SW_COUNT-1:0]  sw_i,
    output logic [BTN_COUNT-1:0] btn_o,
    output logic [SW_COUNT-1:0] sw_o,

    input  lock_vec_t           lock_i,
    input  led_t                core_led_i,
    output led_t                led_o,

    // Copper PHY management
    input  wire                 phy_mdio_i,
    output logic                phy_mdc_o,
    output logic                phy_mdio_o,
    output logic                phy_mdio_oe_o,
    output logic                init_done_o
);

    gpio_in_t  gpio_db;
    reg_addr_t cmd_reg_addr;
    reg_data_t cmd_data;
    logic      cmd_valid;
    logic      cmd_ready;

    switch_debounce #(
        .RATE(DEBOUNCE_RATE)
    ) debounce_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .raw_i         ({btn_i, sw_i}),
        .db_o          (gpio_db)
    );

    assign btn_o = gpio_db[BTN_COUNT+SW_COUNT-1:SW_COUNT];
    assign sw_o  = gpio_db[SW_COUNT-1:0];

    // Debounced switch 0 shows block lock instead of the core LEDs
    assign led_o = gpio_db[0] ? lock_i : core_led_i;

    phy_init_sequencer #(
        .INIT_DELAY(INIT_DELAY)
    ) phy_init_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_ready_i   (cmd_ready),
        .cmd_reg_addr_o(cmd_reg_addr),
        .cmd_data_o    (cmd_data),
        .cmd_valid_o   (cmd_valid),
        .init_done_o   (init_done_o)
    );

    mdio_master mdio_master_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_125mhz_int(rst_125mhz_int),
        .cmd_reg_addr_i(cmd_reg_addr),
        .cmd_data_i    (cmd_data),
        .cmd_valid_i   (cmd_valid),
        .cmd_ready_o   (cmd_ready),
        .phy_mdio_i    (phy_mdio_i),
        .phy_mdc_o     (phy_mdc_o),
        .phy_mdio_o    (phy_mdio_o),
        .phy_mdio_oe_o (phy_mdio_oe_o)
    );

endmodule

`default_nettype wire

//--- hdl/mdio_master.sv
// MDIO master that serializes one clause-22 write frame per accepted command
`default_nettype none
`timescale 1ns/1ps

module mdio_master
    import mdio_pkg::*;
(
    input  wire       clk_125mhz_int,
    input  wire       rst_125mhz_int,
    input  reg_addr_t cmd_reg_addr_i,
    input  reg_data_t cmd_data_i,
    input  wire       cmd_valid_i,
    output logic      cmd_ready_o,
    // Write-only master, read data on this pin is never sampled
    input  wire       phy_mdio_i,
    output logic      phy_mdc_o,
    output logic      phy_mdio_o,
    output logic      phy_mdio_oe_o
);

    localparam int PRESC_W = (MDIO_PRESCALE > 0) ? $clog2(MDIO_PRESCALE + 1) : 1;
    localparam int BIT_W   = $clog2(MDIO_FRAME_BITS);

    logic                       busy;
    logic                       mdc_reg;
    logic                       oe_reg;
    logic [PRESC_W-1:0]         presc_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [MDIO_FRAME_BITS-1:0] frame;
    logic [MDIO_FRAME_BITS-1:0] shift_reg;
    logic                       presc_wrap;
    logic                       mdc_fall;
    logic                       accept;

    // Preamble, ST, OP, PHYAD, REGAD, TA, DATA
    assign frame = {
        {MDIO_PREAMBLE_BITS{1'b1}},
        MDIO_START,
        MDIO_OP_WRITE,
        MDIO_PHY_ADDR,
        cmd_reg_addr_i,
        MDIO_TURNAROUND,
        cmd_data_i
    };

    assign accept     = cmd_valid_i && !busy;
    assign presc_wrap = (presc_cnt == PRESC_W'(MDIO_PRESCALE));
    assign mdc_fall   = busy && presc_wrap && mdc_reg;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy      <= 1'b0;
            mdc_reg   <= 1'b0;
            oe_reg    <= 1'b0;
            presc_cnt <= '0;
            bit_cnt   <= '0;
        end else if (!busy) begin
            presc_cnt <= '0;
            mdc_reg   <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                oe_reg  <= 1'b1;
                bit_cnt <= '0;
            end
        end else if (presc_wrap) begin
            presc_cnt <= '0;
            mdc_reg   <= ~mdc_reg;
            // Falling edge ends the current bit
            if (mdc_reg) begin
                if (bit_cnt == BIT_W'(MDIO_FRAME_BITS - 1)) begin
                    busy   <= 1'b0;
                    oe_reg <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // MSB first, next bit appears on the falling MDC edge
    always_ff @(posedge clk_125mhz_int) begin
        if (accept) begin
            shift_reg <= frame;
        end else if (mdc_fall) begin
            shift_reg <= {shift_reg[MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign cmd_ready_o   = !busy;
    assign phy_mdc_o     = mdc_reg;
    assign phy_mdio_o    = shift_reg[MDIO_FRAME_BITS-1];
    assign phy_mdio_oe_o = oe_reg;

endmodule

`default_nettype wire

//--- hdl/phy_init_sequencer.sv
// PHY init sequencer issuing the indirect extended-register writes after a power-up delay
`default_nettype none
`timescale 1ns/1ps

module phy_init_sequencer
    import board_pkg::*;
    import mdio_pkg::*;
#(
    parameter int INIT_DELAY = INIT_DELAY_DEFAULT
) (
    input  wire       clk_125mhz_int,
    input  wire       rst_125mhz_int,
    input  wire       cmd_ready_i,
    output reg_addr_t cmd_reg_addr_o,
    output reg_data_t cmd_data_o,
    output logic      cmd_valid_o,
    output logic      init_done_o
);

    localparam int DELAY_W = (INIT_DELAY > 0) ? $clog2(INIT_DELAY + 1) : 1;
    localparam int IDX_W   = (EXT_WRITE_COUNT > 1) ? $clog2(EXT_WRITE_COUNT) : 1;

    typedef enum logic [1:0] {
        WAIT_DELAY,
        ISSUE,
        WAIT_ACCEPT,
        DONE
    } state_t;

    state_t             state;
    logic [DELAY_W-1:0] delay_cnt;
    logic [IDX_W-1:0]   ext_idx;
    logic [1:0]         step;
    reg_data_t          ext_addr;
    reg_data_t          ext_data;
    reg_addr_t          next_reg_addr;
    reg_data_t          next_data;

    // Extended register selected by the write index
    always_comb begin
        case (ext_idx)
            IDX_W'(0): begin
                ext_addr = EXT_ADDR_0;
                ext_data = EXT_DATA_0;
            end
            IDX_W'(1): begin
                ext_addr = EXT_ADDR_1;
                ext_data = EXT_DATA_1;
            end
            default: begin
                ext_addr = EXT_ADDR_2;
                ext_data = EXT_DATA_2;
            end
        endcase
    end

    // Four accesses per write: REGCR, address, REGCR, data
    always_comb begin
        case (step)
            2'd0: begin
                next_reg_addr = REG_REGCR;
                next_data     = REGCR_ADDR_MODE;
            end
            2'd1: begin
                next_reg_addr = REG_ADDAR;
                next_data     = ext_addr;
            end
            2'd2: begin
                next_reg_addr = REG_REGCR;
                next_data     = REGCR_DATA_MODE;
            end
            default: begin
                next_reg_addr = REG_ADDAR;
                next_data     = ext_data;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state       <= WAIT_DELAY;
            delay_cnt   <= DELAY_W'(INIT_DELAY);
            ext_idx     <= '0;
            step        <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            case (state)
                WAIT_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                ISSUE: begin
                    cmd_valid_o <= 1'b1;
                    state       <= WAIT_ACCEPT;
                end
                WAIT_ACCEPT: begin
                    if (cmd_ready_i) begin
                        cmd_valid_o <= 1'b0;
                        step        <= step + 1'b1;
                        state       <= ISSUE;
                        if (step == 2'd3) begin
                            if (ext_idx == IDX_W'(EXT_WRITE_COUNT - 1)) begin
                                state <= DONE;
                            end else begin
                                ext_idx <= ext_idx + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= DONE;
                end
            endcase
        end
    end

    // Command fields only change while valid is low
    always_ff @(posedge clk_125mhz_int) begin
        if (state == ISSUE) begin
            cmd_reg_addr_o <= next_reg_addr;
            cmd_data_o     <= next_data;
        end
    end

    assign init_done_o = (state == DONE);

endmodule

`default_nettype wire

//--- hdl/switch_debounce.sv
// Switch debouncer that moves an output only after several equal periodic samples
`default_nettype none
`timescale 1ns/1ps

module switch_debounce
    import board_pkg::*;
#(
    parameter int RATE = DEBOUNCE_RATE_DEFAULT
) (
    input  wire      clk_125mhz_int,
    input  wire      rst_125mhz_int,
    input  gpio_in_t raw_i,
    output gpio_in_t db_o
);

    localparam int GPIO_W = $bits(gpio_in_t);

    // A rate of one still needs a one-bit counter
    localparam int RATE_W = (RATE > 1) ? $clog2(RATE) : 1;

    logic [RATE_W-1:0]           rate_cnt;
    logic                        sample_stb;
    logic [DEBOUNCE_SAMPLES-1:0] hist [GPIO_W];
    gpio_in_t                    db_reg;

    assign sample_stb = (rate_cnt == RATE_W'(RATE - 1));

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            rate_cnt <= '0;
        end else if (sample_stb) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // Decision uses the history before the new sample is shifted in
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            for (int i = 0; i < GPIO_W; i++) begin
                hist[i] <= '0;
            end
            db_reg <= '0;
        end else if (sample_stb) begin
            for (int i = 0; i < GPIO_W; i++) begin
                hist[i] <= {hist[i][DEBOUNCE_SAMPLES-2:0], raw_i[i]};
                if (&hist[i]) begin
                    db_reg[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    db_reg[i] <= 1'b0;
                end
            end
        end
    end

    assign db_o = db_reg;

endmodule

`default_nettype wire

//--- hdl/mdio_pkg.sv
// MDIO package with clause-22 frame fields and the PHY extended-register setup table
`default_nettype none

package mdio_pkg;

    typedef logic [4:0]  phy_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Copper PHY strap address on the board
    localparam phy_addr_t MDIO_PHY_ADDR = 5'd3;

    // Frame fields
    localparam logic [1:0] MDIO_START      = 2'b01;
    localparam logic [1:0] MDIO_OP_WRITE   = 2'b01;
    localparam logic [1:0] MDIO_TURNAROUND = 2'b10;

    // MDC toggles every PRESCALE+1 clocks, so the period is 8 clocks
    localparam int MDIO_PRESCALE = 3;

    localparam int MDIO_PREAMBLE_BITS = 32;
    localparam int MDIO_FRAME_BITS    = 64;

    // Indirect access registers for the extended address space
    localparam reg_addr_t REG_REGCR = 5'h0D;
    localparam reg_addr_t REG_ADDAR = 5'h0E;

    // REGCR values, device address 0x1F, address mode then data mode
    localparam reg_data_t REGCR_ADDR_MODE = 16'h001F;
    localparam reg_data_t REGCR_DATA_MODE = 16'h401F;

    localparam int EXT_WRITE_COUNT = 3;

    // CFG4, SGMII autonegotiation timer to 11 ms
    localparam reg_data_t EXT_ADDR_0 = 16'h0031;
    localparam reg_data_t EXT_DATA_0 = 16'h0070;

    // SGMIICTL1, enable SGMII clock output
    localparam reg_data_t EXT_ADDR_1 = 16'h00D3;
    localparam reg_data_t EXT_DATA_1 = 16'h4000;

    // 10M_SGMII_CFG, allow 10 Mb/s operation
    localparam reg_data_t EXT_ADDR_2 = 16'h016F;
    localparam reg_data_t EXT_DATA_2 = 16'h0015;

endpackage

`default_nettype wire

//--- hdl/board_pkg.sv
// Board package with GPIO and LED widths, debounce constants and the PHY power-up delay
`default_nettype none

package board_pkg;

    // Five buttons and four switches share one debounced vector
    localparam int BTN_COUNT = 5;
    localparam int SW_COUNT  = 4;

    // Order is btn u, l, d, r, c, then sw[3:0]; switch 0 sits in bit 0
    typedef logic [BTN_COUNT+SW_COUNT-1:0] gpio_in_t;

    // User LED word
    typedef logic [7:0] led_t;

    // QSFP1 lanes 1-4 in bits 3:0, QSFP2 lanes 1-4 in bits 7:4
    typedef logic [7:0] lock_vec_t;

    // Equal samples needed before a debounced output moves
    localparam int DEBOUNCE_SAMPLES = 4;

    // Clocks between samples, about 1.25 ms at 125 MHz
    localparam int DEBOUNCE_RATE_DEFAULT = 156000;

    // Wait after reset before touching the PHY, roughly 8 ms
    localparam int INIT_DELAY_DEFAULT = (1 << 20) - 1;

endpackage

`default_nettype wire
